// ==== Makefile ====
# Verilator build and run of the edge data unit testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_cu_edge_data_unit -f sim.f -o sim_tb

# Pass or fail is taken from the log only
run: compile
	./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1; true
	@cat sim.log
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/cu_apb_regs.sv ====
/*
 * APB register file
 *   Control word, vertex base address, issued-command count
 *   Write window into the vertex-data memory
 */
`timescale 1ns/1ps
`include "cu_cfg.svh"

module cu_apb_regs (
	input  logic                  clock,
	input  logic                  rstn,
	input  cu_pkg::apb_req_t      apb,
	output logic [31:0]           prdata,
	input  logic                  cmd_issued,
	output cu_pkg::cu_ctrl_u      ctrl,
	output logic [31:0]           base_address,
	output logic                  mem_write_en,
	output logic [`CU_MEM_AW-1:0] mem_write_addr,
	output logic [31:0]           mem_write_data
);

	localparam int WIN_BYTES  = `CU_DATA_SIZE_READ << `CU_MEM_AW;
	localparam int WORD_SHIFT = $clog2(`CU_DATA_SIZE_READ);

	logic             wr_access;
	logic             rd_access;
	logic             win_hit;
	logic             ctrl_wr;
	logic [11:0]      win_offset;
	cu_pkg::cu_ctrl_u wr_ctrl;
	logic [31:0]      cmd_count;

	// Access phase completes every transfer
	assign wr_access = apb.psel && apb.penable && apb.pwrite;
	assign rd_access = apb.psel && apb.penable && !apb.pwrite;

	assign win_hit = (int'(apb.paddr) >= `CU_APB_MEM_WIN) &&
		(int'(apb.paddr) < `CU_APB_MEM_WIN + WIN_BYTES);
	assign win_offset = apb.paddr - `CU_APB_MEM_WIN;

	// Incoming word seen as control fields
	assign wr_ctrl.raw = apb.pwdata;
	assign ctrl_wr     = wr_access && (apb.paddr == `CU_APB_CTRL);

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ctrl         <= '0;
			base_address <= '0;
		end else begin
			if (ctrl_wr) begin
				ctrl <= wr_ctrl;
			end
			if (wr_access && (apb.paddr == `CU_APB_BASE)) begin
				base_address <= apb.pwdata;
			end
		end
	end

	// Cleared by writing enable low
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_count <= '0;
		end else if (ctrl_wr && !wr_ctrl.fields.enable) begin
			cmd_count <= '0;
		end else if (cmd_issued) begin
			cmd_count <= cmd_count + 1'b1;
		end
	end

	// Memory window writes land at the access edge
	assign mem_write_en   = wr_access && win_hit;
	assign mem_write_addr = win_offset[WORD_SHIFT +: `CU_MEM_AW];
	assign mem_write_data = apb.pwdata;

	////////////////////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		prdata = '0;
		if (rd_access) begin
			case (apb.paddr)
				`CU_APB_CTRL:  prdata = ctrl.raw;
				`CU_APB_BASE:  prdata = base_address;
				`CU_APB_COUNT: prdata = cmd_count;
				default:       prdata = '0;
			endcase
		end
	end

endmodule

// ==== hdl/cu_cfg.svh ====
/*
 * Configuration macros for the edge data path
 *   Buffer depth and almost-full margin
 *   Vertex-data memory geometry
 *   APB register map and unit identifier
 */
`ifndef CU_CFG_SVH
`define CU_CFG_SVH

// Depth of every FIFO in the path
`define CU_EDGE_BUFFER_DEPTH 16
// Free slots left once almost-full rises
`define CU_ALFULL_MARGIN 4

// Vertex memory word-address width, 256 words
`define CU_MEM_AW 8
// Bytes per vertex data word
`define CU_DATA_SIZE_READ 4

// APB register map
`define CU_APB_CTRL 12'h000
`define CU_APB_BASE 12'h004
`define CU_APB_COUNT 12'h008
`define CU_APB_MEM_WIN 12'h400

`define CU_ID_VALUE 3

`endif

// ==== hdl/cu_edge_data_control.sv ====
/*
 * Edge data control
 *   Edge job buffer fed from the upstream handshake
 *   Read command generation, base + dest * word size
 *   Command buffer towards memory, data buffer towards consumer
 */
`timescale 1ns/1ps
`include "cu_cfg.svh"

module cu_edge_data_control #(
	parameter int CU_ID = 1
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  cu_pkg::cu_ctrl_u      ctrl,
	input  logic [31:0]           base_address,
	input  cu_pkg::edge_job_t     edge_job,
	output logic                  edge_request,
	output cu_pkg::read_command_t read_command,
	output logic                  cmd_issued,
	input  cu_pkg::edge_data_t    read_response,
	input  logic                  edge_data_request,
	output cu_pkg::edge_data_t    edge_data
);

	localparam int WORD_SHIFT = $clog2(`CU_DATA_SIZE_READ);

	// Latched input job and buffer heads
	cu_pkg::edge_job_t      job_in;
	cu_pkg::edge_job_t      job_head;
	cu_pkg::read_command_t  cmd_next;

	cu_pkg::buffer_status_t job_status;
	cu_pkg::buffer_status_t cmd_status;
	cu_pkg::buffer_status_t data_status;

	logic job_pop;
	logic cmd_pop;
	logic data_pop;

	////////////////////////////////////////////////////////////////////////////
	// Edge job buffer
	////////////////////////////////////////////////////////////////////////////

	// Margin absorbs jobs still in flight from the source
	assign edge_request = ctrl.fields.enable && !job_status.alfull;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_in <= '0;
		end else begin
			job_in <= edge_job;
		end
	end

	// Stall while the command buffer nears full
	assign job_pop = !job_status.empty && !cmd_status.alfull;

	fifo #(
		.WIDTH($bits(cu_pkg::edge_job_t)),
		.DEPTH(`CU_EDGE_BUFFER_DEPTH)
	) i_job_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_in.valid),
		.data_in (job_in),
		.pop     (job_pop),
		.data_out(job_head),
		.status  (job_status)
	);

	////////////////////////////////////////////////////////////////////////////
	// Read command generation
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_next <= '0;
		end else begin
			cmd_next <= '0;
			if (job_head.valid) begin
				cmd_next.valid            <= 1'b1;
				// Byte address of the destination vertex word
				cmd_next.address          <= base_address +
					(32'(job_head.dest) << WORD_SHIFT);
				cmd_next.cacheline_offset <= job_head.dest[3:0];
				cmd_next.cu_id            <= 4'(CU_ID);
				cmd_next.abt              <= ctrl.fields.abt;
				cmd_next.dest             <= job_head.dest;
				// Hint selects a cached read
				if (ctrl.fields.cache_hint) begin
					cmd_next.command <= cu_pkg::READ_CL_S;
				end else begin
					cmd_next.command <= cu_pkg::READ_CL_NA;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command buffer
	////////////////////////////////////////////////////////////////////////////

	// Hold back while responses could overrun the data buffer
	assign cmd_pop = !cmd_status.empty && !data_status.alfull;

	fifo #(
		.WIDTH($bits(cu_pkg::read_command_t)),
		.DEPTH(`CU_EDGE_BUFFER_DEPTH)
	) i_cmd_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_next.valid),
		.data_in (cmd_next),
		.pop     (cmd_pop),
		.data_out(read_command),
		.status  (cmd_status)
	);

	// One pulse per command sent to memory
	assign cmd_issued = read_command.valid;

	////////////////////////////////////////////////////////////////////////////
	// Edge data buffer
	////////////////////////////////////////////////////////////////////////////

	assign data_pop = edge_data_request && !data_status.empty;

	fifo #(
		.WIDTH($bits(cu_pkg::edge_data_t)),
		.DEPTH(`CU_EDGE_BUFFER_DEPTH)
	) i_data_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (read_response.valid),
		.data_in (read_response),
		.pop     (data_pop),
		.data_out(edge_data),
		.status  (data_status)
	);

endmodule

// ==== hdl/cu_edge_data_unit.sv ====
/*
 * Edge data unit top level
 *   APB registers, edge data control and graph data memory
 */
`timescale 1ns/1ps
`include "cu_cfg.svh"

module cu_edge_data_unit (
	input  logic               clock,
	input  logic               rstn,
	input  cu_pkg::apb_req_t   apb,
	output logic [31:0]        prdata,
	input  cu_pkg::edge_job_t  edge_job,
	output logic               edge_request,
	input  logic               edge_data_request,
	output cu_pkg::edge_data_t edge_data
);

	// Register outputs
	cu_pkg::cu_ctrl_u      ctrl;
	logic [31:0]           base_address;
	logic                  mem_write_en;
	logic [`CU_MEM_AW-1:0] mem_write_addr;
	logic [31:0]           mem_write_data;

	// Control to memory and back
	logic                  cmd_issued;
	cu_pkg::read_command_t read_command;
	cu_pkg::edge_data_t    read_response;

	cu_apb_regs i_regs (
		.clock         (clock),
		.rstn          (rstn),
		.apb           (apb),
		.prdata        (prdata),
		.cmd_issued    (cmd_issued),
		.ctrl          (ctrl),
		.base_address  (base_address),
		.mem_write_en  (mem_write_en),
		.mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data)
	);

	cu_edge_data_control #(
		.CU_ID(`CU_ID_VALUE)
	) i_control (
		.clock            (clock),
		.rstn             (rstn),
		.ctrl             (ctrl),
		.base_address     (base_address),
		.edge_job         (edge_job),
		.edge_request     (edge_request),
		.read_command     (read_command),
		.cmd_issued       (cmd_issued),
		.read_response    (read_response),
		.edge_data_request(edge_data_request),
		.edge_data        (edge_data)
	);

	cu_graph_data_memory i_memory (
		.clock        (clock),
		.rstn         (rstn),
		.write_en     (mem_write_en),
		.write_addr   (mem_write_addr),
		.write_data   (mem_write_data),
		.read_command (read_command),
		.read_response(read_response)
	);

endmodule

// ==== hdl/cu_graph_data_memory.sv ====
/*
 * Graph data memory
 *   256-word vertex-data RAM, written over APB
 *   Two-stage read pipeline returning tagged responses
 */
`timescale 1ns/1ps
`include "cu_cfg.svh"

module cu_graph_data_memory (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  write_en,
	input  logic [`CU_MEM_AW-1:0] write_addr,
	input  logic [31:0]           write_data,
	input  cu_pkg::read_command_t read_command,
	output cu_pkg::edge_data_t    read_response
);

	localparam int WORDS      = 1 << `CU_MEM_AW;
	localparam int WORD_SHIFT = $clog2(`CU_DATA_SIZE_READ);

	logic [31:0] mem [WORDS];

	// Stage 1, address decode
	logic                  s1_valid;
	logic [15:0]           s1_dest;
	logic [`CU_MEM_AW-1:0] s1_index;

	// Stage 2, RAM output
	logic                  s2_valid;
	logic [15:0]           s2_dest;
	logic [31:0]           s2_data;

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (write_en) begin
			mem[write_addr] <= write_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read pipeline
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= read_command.valid;
			s2_valid <= s1_valid;
		end
	end

	// Word index wraps modulo memory size
	always_ff @(posedge clock) begin
		s1_index <= read_command.address[WORD_SHIFT +: `CU_MEM_AW];
		s1_dest  <= read_command.dest;
		s2_data  <= mem[s1_index];
		s2_dest  <= s1_dest;
	end

	assign read_response.valid = s2_valid;
	assign read_response.dest  = s2_dest;
	assign read_response.data  = s2_data;

endmodule

// ==== hdl/cu_pkg.sv ====
/*
 * Shared types of the edge data path
 *   Edge job, read command and edge data words
 *   Read command encoding and buffer status
 *   Control word union and APB request bundle
 */
package cu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data path words
	////////////////////////////////////////////////////////////////////////////

	// One edge job from upstream
	typedef struct packed {
		logic        valid;
		logic [15:0] edge_id;
		logic [15:0] dest;
	} edge_job_t;

	// Cached or non-allocating read
	typedef enum logic [1:0] {
		READ_CL_S,
		READ_CL_NA
	} read_cmd_e;

	// Read command towards graph data memory
	typedef struct packed {
		logic        valid;
		logic [31:0] address;
		logic [3:0]  cacheline_offset;
		logic [3:0]  cu_id;
		logic [2:0]  abt;
		read_cmd_e   command;
		// Requesting vertex, comes back as the response tag
		logic [15:0] dest;
	} read_command_t;

	// Memory response and buffered output share one layout
	typedef struct packed {
		logic        valid;
		logic [15:0] dest;
		logic [31:0] data;
	} edge_data_t;

	typedef struct packed {
		logic valid;
		logic empty;
		logic alfull;
		logic full;
	} buffer_status_t;

	////////////////////////////////////////////////////////////////////////////
	// Control and bus
	////////////////////////////////////////////////////////////////////////////

	// Field view of the control word, bit 0 at the bottom
	typedef struct packed {
		logic [26:0] reserved;
		logic        cache_hint;
		logic [2:0]  abt;
		logic        enable;
	} cu_ctrl_fields_t;

	// Raw APB word or decoded fields
	typedef union packed {
		logic [31:0]     raw;
		cu_ctrl_fields_t fields;
	} cu_ctrl_u;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

endpackage

// ==== hdl/fifo.sv ====
/*
 * Synchronous FIFO
 *   Circular storage with read and write pointers
 *   Registered pop output, cleared when idle
 *   Full, almost-full, empty and valid status
 */
`timescale 1ns/1ps
`include "cu_cfg.svh"

module fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = `CU_EDGE_BUFFER_DEPTH
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   push,
	input  logic [WIDTH-1:0]       data_in,
	input  logic                   pop,
	output logic [WIDTH-1:0]       data_out,
	output cu_pkg::buffer_status_t status
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PW-1:0]    wr_ptr;
	logic [PW-1:0]    rd_ptr;
	logic [CW-1:0]    count;
	logic             do_push;
	logic             do_pop;
	logic             pop_valid;

	// Overflow and underflow guarded here
	assign do_push = push && (count != CW'(DEPTH));
	assign do_pop  = pop && (count != '0);

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// Pointers wrap at DEPTH
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			pop_valid <= 1'b0;
			data_out  <= '0;
		end else begin
			pop_valid <= do_pop;
			// Head word shows for one cycle only
			data_out  <= do_pop ? mem[rd_ptr] : '0;
			if (do_push) begin
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign status.valid  = pop_valid;
	assign status.empty  = (count == '0);
	assign status.full   = (count == CW'(DEPTH));
	assign status.alfull = (count >= CW'(DEPTH - `CU_ALFULL_MARGIN));

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/cu_pkg.sv
hdl/fifo.sv
hdl/cu_apb_regs.sv
hdl/cu_edge_data_control.sv
hdl/cu_graph_data_memory.sv
hdl/cu_edge_data_unit.sv
testbench/cu_edge_data_chk.sv
testbench/tb_cu_edge_data_unit.sv

// ==== testbench/cu_edge_data_chk.sv ====
/*
 * Concurrent checks on the edge data control
 *   Job handshake against edge_request
 *   No push into a full FIFO
 *   Memory response two cycles after its command
 */
`timescale 1ns/1ps

module cu_edge_data_chk (
	input logic                  clock,
	input logic                  rstn,
	input cu_pkg::edge_job_t     edge_job,
	input logic                  edge_request,
	input logic                  job_push,
	input logic                  job_full,
	input logic                  cmd_push,
	input logic                  cmd_full,
	input logic                  data_push,
	input logic                  data_full,
	input cu_pkg::read_command_t read_command,
	input cu_pkg::edge_data_t    read_response
);

	////////////////////////////////////////////////////////////////////////////
	// Upstream handshake
	////////////////////////////////////////////////////////////////////////////

	// Job only in the cycle after a request edge
	job_after_request: assert property (@(posedge clock) disable iff (!rstn)
		edge_job.valid |-> $past(edge_request))
	else begin
		tb_cu_edge_data_unit.assert_fail_count += 1;
		$error("edge job offered without edge_request at the previous edge");
	end

	////////////////////////////////////////////////////////////////////////////
	// Buffer safety
	////////////////////////////////////////////////////////////////////////////

	no_push_when_full: assert property (@(posedge clock) disable iff (!rstn)
		!((job_push && job_full) || (cmd_push && cmd_full) ||
		(data_push && data_full)))
	else begin
		tb_cu_edge_data_unit.assert_fail_count += 1;
		$error("push into a full FIFO");
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory latency
	////////////////////////////////////////////////////////////////////////////

	// Every command answered two cycles later
	cmd_answered: assert property (@(posedge clock) disable iff (!rstn)
		$past(read_command.valid, 2) |-> read_response.valid)
	else begin
		tb_cu_edge_data_unit.assert_fail_count += 1;
		$error("read command got no response two cycles later");
	end

	// And no response without a command, tag carried through
	response_tagged: assert property (@(posedge clock) disable iff (!rstn)
		read_response.valid |-> ($past(read_command.valid, 2) &&
		(read_response.dest == $past(read_command.dest, 2))))
	else begin
		tb_cu_edge_data_unit.assert_fail_count += 1;
		$error("read response without matching command two cycles earlier");
	end

endmodule

// ==== testbench/tb_cu_edge_data_unit.sv ====
/*
 * Testbench for the edge data unit
 *   Clock, reset, APB transfers and vertex memory fill
 *   Job table source, back-pressuring consumer and output monitor
 *   Compare tasks, error counts and watchdog
 */
`timescale 1ns/1ps
`include "cu_cfg.svh"

module tb_cu_edge_data_unit;

	typedef struct packed {
		logic [15:0] edge_id;
		logic [15:0] dest;
	} job_entry_t;

	localparam int TABLE_LEN      = 12;
	localparam int REPS           = 4;
	localparam int PASSES         = 2;
	localparam int TIMEOUT_CYCLES = 40 * TABLE_LEN * REPS * PASSES + 2000;
	localparam int MEM_WORDS      = 1 << `CU_MEM_AW;

	// Dests spread over and past the 256-word window
	job_entry_t job_table [TABLE_LEN] = '{
		'{16'h0001, 16'h0000}, '{16'h0002, 16'h0001}, '{16'h0003, 16'h0005},
		'{16'h0004, 16'h003F}, '{16'h0005, 16'h0040}, '{16'h0006, 16'h00C8},
		'{16'h0007, 16'h00FF}, '{16'h0008, 16'h0100}, '{16'h0009, 16'h03E8},
		'{16'h000A, 16'h7FFF}, '{16'h000B, 16'hFFFF}, '{16'h000C, 16'h002A}
	};

	logic               clock;
	logic               rstn;
	cu_pkg::apb_req_t   apb;
	logic [31:0]        prdata;
	cu_pkg::edge_job_t  edge_job;
	logic               edge_request;
	logic               edge_data_request;
	cu_pkg::edge_data_t edge_data;

	// Reference copy of the vertex memory
	logic [31:0]        model [MEM_WORDS];
	logic [31:0]        cur_base;
	cu_pkg::edge_data_t expected_q [$];
	logic               consumer_hold;
	logic               saw_stall;
	int                 value_errors = 0;
	int                 other_errors = 0;
	int                 assert_fail_count = 0;
	int                 cycle_count = 0;

	cu_edge_data_unit i_dut (
		.clock            (clock),
		.rstn             (rstn),
		.apb              (apb),
		.prdata           (prdata),
		.edge_job         (edge_job),
		.edge_request     (edge_request),
		.edge_data_request(edge_data_request),
		.edge_data        (edge_data)
	);

	bind cu_edge_data_control cu_edge_data_chk i_chk (
		.clock        (clock),
		.rstn         (rstn),
		.edge_job     (edge_job),
		.edge_request (edge_request),
		.job_push     (job_in.valid),
		.job_full     (job_status.full),
		.cmd_push     (cmd_next.valid),
		.cmd_full     (cmd_status.full),
		.data_push    (read_response.valid),
		.data_full    (data_status.full),
		.read_command (read_command),
		.read_response(read_response)
	);

	// 40 ns period
	initial begin : clock_gen
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Expected values and compare tasks
	////////////////////////////////////////////////////////////////////////////

	// Byte address over word size gives the wrapped word index
	function automatic int vertex_index(input logic [31:0] base, input logic [15:0] dest);
		logic [31:0] byte_addr;
		byte_addr = base + 32'(dest) * `CU_DATA_SIZE_READ;
		return int'((byte_addr / `CU_DATA_SIZE_READ) % MEM_WORDS);
	endfunction

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Raw view and the decoded fields
	task automatic check_ctrl(input cu_pkg::cu_ctrl_u got, input cu_pkg::cu_ctrl_u exp);
		if (got.raw !== exp.raw) begin
			value_errors++;
			$display("[FAIL] %0t ctrl.raw: got %h expected %h", $time, got.raw, exp.raw);
		end
		if ((got.fields.enable !== exp.fields.enable) ||
			(got.fields.abt !== exp.fields.abt) ||
			(got.fields.cache_hint !== exp.fields.cache_hint)) begin
			value_errors++;
			$display("[FAIL] %0t ctrl.fields en/abt/hint: got %b/%0d/%b expected %b/%0d/%b",
				$time, got.fields.enable, got.fields.abt, got.fields.cache_hint,
				exp.fields.enable, exp.fields.abt, exp.fields.cache_hint);
		end
	endtask

	task automatic check_edge_data(input cu_pkg::edge_data_t got,
		input cu_pkg::edge_data_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[FAIL] %0t edge_data: got dest=%h data=%h expected dest=%h data=%h",
				$time, got.dest, got.data, exp.dest, exp.data);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// APB transfers as setup then access
	////////////////////////////////////////////////////////////////////////////

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
		@(posedge clock);
		apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(posedge clock);
		apb.penable <= 1'b1;
		@(posedge clock);
		apb <= '0;
	endtask

	// prdata taken mid access phase
	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
		@(posedge clock);
		apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
		@(posedge clock);
		apb.penable <= 1'b1;
		@(negedge clock);
		data = prdata;
		@(posedge clock);
		apb <= '0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Job source and drain
	////////////////////////////////////////////////////////////////////////////

	// One job per cycle and only after a request edge
	task automatic apply_jobs(input int reps);
		cu_pkg::edge_job_t  job;
		cu_pkg::edge_data_t exp;
		for (int rep = 0; rep < reps; rep++) begin
			for (int t = 0; t < TABLE_LEN; t++) begin
				@(posedge clock);
				while (!edge_request) begin
					edge_job <= '0;
					saw_stall = 1'b1;
					@(posedge clock);
				end
				job.valid   = 1'b1;
				job.edge_id = job_table[t].edge_id + 16'(16 * rep);
				job.dest    = job_table[t].dest;
				edge_job <= job;
				exp.valid = 1'b1;
				exp.dest  = job.dest;
				exp.data  = model[vertex_index(cur_base, job.dest)];
				expected_q.push_back(exp);
			end
		end
		@(posedge clock);
		edge_job <= '0;
	endtask

	task automatic wait_drain();
		while (expected_q.size() != 0) begin
			@(posedge clock);
		end
		repeat (4) @(posedge clock);
	endtask

	// Disabled unit never asks for jobs
	task automatic expect_idle(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			if (edge_request) begin
				other_errors++;
				$display("edge_request is high at %0t while the unit is disabled", $time);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Consumer, monitor and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin : consumer
		int   stretch;
		logic want;
		stretch = 0;
		want = 1'b0;
		edge_data_request = 1'b0;
		wait (rstn === 1'b1);
		forever begin
			@(posedge clock);
			// New stretch of requesting or withholding
			if (stretch == 0) begin
				want = ($urandom_range(3, 0) != 0);
				stretch = $urandom_range(8, 1);
			end
			stretch--;
			edge_data_request <= want && !consumer_hold;
		end
	end

	// Outputs in job order
	initial begin : monitor
		cu_pkg::edge_data_t exp;
		forever begin
			@(posedge clock);
			if (edge_data.valid) begin
				if (expected_q.size() == 0) begin
					other_errors++;
					$display("Output at %0t with no job outstanding", $time);
				end else begin
					exp = expected_q.pop_front();
					check_edge_data(edge_data, exp);
				end
			end
		end
	end

	initial begin : watchdog
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the run did not finish", cycle_count);
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : main
		cu_pkg::cu_ctrl_u ctrl_word;
		logic [31:0]      rd;
		logic [31:0]      word;
		void'($urandom(37526));
		rstn = 1'b0;
		apb = '0;
		edge_job = '0;
		consumer_hold = 1'b1;
		saw_stall = 1'b0;
		cur_base = '0;
		repeat (10) @(posedge clock);
		rstn <= 1'b1;
		expect_idle(20);

		// Random vertex data mirrored in the model
		for (int i = 0; i < MEM_WORDS; i++) begin
			word = $urandom;
			model[i] = word;
			apb_write(12'(`CU_APB_MEM_WIN + i * `CU_DATA_SIZE_READ), word);
		end

		// First pass with cached reads
		cur_base = 32'h0000_0100;
		apb_write(`CU_APB_BASE, cur_base);
		ctrl_word = '0;
		ctrl_word.fields.enable = 1'b1;
		ctrl_word.fields.abt = 3'd5;
		ctrl_word.fields.cache_hint = 1'b1;
		apb_write(`CU_APB_CTRL, ctrl_word.raw);
		apb_read(`CU_APB_CTRL, rd);
		check_ctrl(rd, ctrl_word);
		apb_read(`CU_APB_BASE, rd);
		check_word("base_address", rd, cur_base);
		// Consumer held off first so every buffer fills
		fork
			apply_jobs(REPS);
			begin
				repeat (300) @(posedge clock);
				consumer_hold <= 1'b0;
			end
		join
		wait_drain();
		if (!saw_stall) begin
			other_errors++;
			$display("edge_request never fell while the path was full");
		end
		apb_read(`CU_APB_COUNT, rd);
		check_word("cmd_count", rd, 32'(TABLE_LEN * REPS));

		// Enable low clears the count
		ctrl_word.fields.enable = 1'b0;
		apb_write(`CU_APB_CTRL, ctrl_word.raw);
		apb_read(`CU_APB_COUNT, rd);
		check_word("cmd_count", rd, 32'd0);
		expect_idle(20);

		// Second pass with a new base and non-allocating reads
		cur_base = 32'h0001_0F3C;
		apb_write(`CU_APB_BASE, cur_base);
		ctrl_word.fields.enable = 1'b1;
		ctrl_word.fields.abt = 3'd2;
		ctrl_word.fields.cache_hint = 1'b0;
		apb_write(`CU_APB_CTRL, ctrl_word.raw);
		apb_read(`CU_APB_CTRL, rd);
		check_ctrl(rd, ctrl_word);
		apply_jobs(REPS);
		wait_drain();
		apb_read(`CU_APB_COUNT, rd);
		check_word("cmd_count", rd, 32'(TABLE_LEN * REPS));

		$display("Errors: %0d value, %0d other, %0d assertion",
			value_errors, other_errors, assert_fail_count);
		if ((value_errors + other_errors + assert_fail_count) == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
